//--- hdl/fma16_macros.svh
// fma16 constants
// datapath widths, AXI4-Lite register map and register bit positions
`ifndef FMA16_MACROS_SVH
`define FMA16_MACROS_SVH

`define FMA_SUM_W       36      // aligned sum vector, product + carry + guard
`define FMA_GUARD_BITS  8       // guard bits below the product lsb

`define AXIL_ADDR_W     4
`define AXIL_DATA_W     32

`define REG_XY          4'h0    // x low half, y high half
`define REG_Z           4'h4    // z and rounding mode
`define REG_CTRL        4'h8    // write-only start
`define REG_STATUS      4'hC    // result, done, inexact

`define CTRL_START_BIT  0
`define Z_RM_LSB        16      // rounding mode in bits 17:16
`define STAT_DONE_BIT   16
`define STAT_NX_BIT     17

`endif

//--- hdl/fma16_pkg.sv
// fma16 shared types
// half-precision word, pipeline stage records and AXI4-Lite channel bundles
`include "fma16_macros.svh"

package fma16_pkg;

    typedef struct packed {
        logic       sign;
        logic [4:0] exp;
        logic [9:0] frac;
    } fp16_t;

    typedef enum logic [1:0] {
        RND_NEAR_EVEN = 2'd0,
        RND_ZERO      = 2'd1,
        RND_DOWN      = 2'd2,
        RND_UP        = 2'd3
    } round_mode_e;

    typedef struct packed {
        fp16_t       x;
        fp16_t       y;
        fp16_t       z;
        round_mode_e rm;
    } fma_req_t;

    // stage 1 -> stage 2
    typedef struct packed {
        logic [`FMA_SUM_W-1:0] sm;      // magnitude of x*y+z, bit 28 weighs 2^(re-15)
        logic                  ms;      // result sign, zero sign already resolved
        logic signed [6:0]     re;      // reference exponent
        logic                  sticky;  // bits lost in alignment
        logic                  zero;    // exact zero
        round_mode_e           rm;
    } sum_stage_t;

    typedef struct packed {
        logic        sign;
        logic [4:0]  exp;
        logic [10:0] man;   // hidden bit included, 0 for subnormals
        logic        g;
        logic        r;
        logic        s;
        round_mode_e rm;
    } norm_stage_t;

    typedef struct packed {
        fp16_t result;
        logic  nx;
    } fma_rsp_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_e;

    typedef struct packed {
        logic [`AXIL_ADDR_W-1:0]   awaddr;
        logic                      awvalid;
        logic [`AXIL_DATA_W-1:0]   wdata;
        logic [`AXIL_DATA_W/8-1:0] wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`AXIL_ADDR_W-1:0]   araddr;
        logic                      arvalid;
        logic                      rready;
    } axil_req_t;

    typedef struct packed {
        logic                    awready;
        logic                    wready;
        resp_e                   bresp;
        logic                    bvalid;
        logic                    arready;
        logic [`AXIL_DATA_W-1:0] rdata;
        resp_e                   rresp;
        logic                    rvalid;
    } axil_rsp_t;

endpackage

//--- hdl/fma16_round.sv
// fma16 rounding
// applies the rounding mode to the normalized mantissa, carries into
// the exponent on overflow and flags an inexact result
`timescale 1ns/1ns

module fma16_round (
    input  fma16_pkg::norm_stage_t norm,
    output fma16_pkg::fp16_t       result,
    output logic                   nx
);
    import fma16_pkg::*;

    logic        inc;
    logic [11:0] man_r;     // one spare bit for the carry

    always_comb
    begin
        nx = norm.g | norm.r | norm.s;

        case (norm.rm)
            RND_NEAR_EVEN: inc = norm.g & (norm.r | norm.s | norm.man[0]);  // ties to even
            RND_ZERO:      inc = 1'b0;
            RND_DOWN:      inc = norm.sign & nx;
            RND_UP:        inc = ~norm.sign & nx;
            default:       inc = 1'b0;
        endcase

        man_r = {1'b0, norm.man} + 12'(inc);

        result.sign = norm.sign;
        // 2047+1 bumps the exponent, a subnormal reaching 1024 becomes exponent 1
        result.exp  = norm.exp + 5'(man_r[11])
                    + 5'((norm.exp == 5'd0) & man_r[10]);
        result.frac = man_r[11] ? man_r[10:1] : man_r[9:0];
    end

endmodule

//--- hdl/fma16_mult_align.sv
// fma16 stage 1
// exact 22-bit product, alignment of z against it, signed add
// and registering of the magnitude, sign and reference exponent
`timescale 1ns/1ns
`include "fma16_macros.svh"

module fma16_mult_align (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  start,
    input  fma16_pkg::fma_req_t   req,
    output logic                  sum_valid,
    output fma16_pkg::sum_stage_t sum
);
    import fma16_pkg::*;

    logic [10:0]             mx, my, mz;           // mantissas with hidden bit
    logic signed [6:0]       ex, ey, ez, pe, d;
    logic [21:0]             pm;                   // exact product
    logic                    ps, eff_sub, prod_big, neg;
    logic                    sign_big, sign_small;
    logic [6:0]              mag7;
    logic [5:0]              sh;
    logic [`FMA_SUM_W-1:0]   pv, zv, big, little, al;
    logic [2*`FMA_SUM_W-1:0] shifted;
    logic [`FMA_SUM_W:0]     diff;
    sum_stage_t              s_d;

    always_comb
    begin
        // exponent 0 reads as 1 without the hidden one
        mx = {|req.x.exp, req.x.frac};
        my = {|req.y.exp, req.y.frac};
        mz = {|req.z.exp, req.z.frac};
        ex = (req.x.exp == 5'd0) ? 7'sd1 : 7'(req.x.exp);
        ey = (req.y.exp == 5'd0) ? 7'sd1 : 7'(req.y.exp);
        ez = (req.z.exp == 5'd0) ? 7'sd1 : 7'(req.z.exp);

        pm = mx * my;
        pe = ex + ey - 7'sd15;           // bias counted once
        ps = req.x.sign ^ req.y.sign;

        // 1.0 sits at bit 28 for both operands
        pv = `FMA_SUM_W'(pm) << `FMA_GUARD_BITS;
        zv = `FMA_SUM_W'(mz) << (`FMA_GUARD_BITS + 10);

        d        = pe - ez;
        prod_big = ~d[6];
        mag7     = prod_big ? d : -d;
        sh       = (mag7 > 7'(`FMA_SUM_W)) ? 6'(`FMA_SUM_W) : mag7[5:0];  // all bits into sticky

        big        = prod_big ? pv : zv;
        little     = prod_big ? zv : pv;
        sign_big   = prod_big ? ps : req.z.sign;
        sign_small = prod_big ? req.z.sign : ps;

        //////////////////////////////
        // alignment
        //////////////////////////////
        shifted      = {little, {`FMA_SUM_W{1'b0}}} >> sh;
        s_d.sticky   = |shifted[`FMA_SUM_W-1:0];
        al           = shifted[2*`FMA_SUM_W-1:`FMA_SUM_W];
        al[0]        = al[0] | s_d.sticky;     // jam keeps the subtract honest

        eff_sub = ps ^ req.z.sign;
        diff    = {1'b0, big} - {1'b0, al};
        neg     = diff[`FMA_SUM_W];

        if (eff_sub)
        begin
            s_d.sm = neg ? -diff[`FMA_SUM_W-1:0] : diff[`FMA_SUM_W-1:0];
            if (s_d.sm == '0)
                s_d.ms = (req.rm == RND_DOWN);  // exact cancellation gives -0 only when rounding down
            else
                s_d.ms = neg ? sign_small : sign_big;
        end
        else
        begin
            s_d.sm = big + al;
            s_d.ms = ps;                          // same signs so zeros keep theirs
        end

        s_d.re   = prod_big ? pe : ez;
        s_d.zero = (s_d.sm == '0) & ~s_d.sticky;
        s_d.rm   = req.rm;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sum_valid <= 1'b0;
        else
            sum_valid <= start;
    end

    always_ff @(posedge clk)
    begin
        if (start)
            sum <= s_d;
    end

endmodule

//--- hdl/fma16_result.sv
// fma16 stage 2
// normalizes the aligned sum, clamps into the subnormal range,
// rounds through fma16_round and registers the result word
`timescale 1ns/1ns
`include "fma16_macros.svh"

module fma16_result (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sum_valid,
    input  fma16_pkg::sum_stage_t sum,
    output logic                  rsp_valid,
    output fma16_pkg::fma_rsp_t   rsp
);
    import fma16_pkg::*;

    logic [5:0]            lzc, sh;
    logic signed [6:0]     lmax, e_nrm;
    logic [`FMA_SUM_W-1:0] nrm;
    norm_stage_t           norm;
    fp16_t                 rnd;
    logic                  nx;

    //////////////////////////////
    // normalization
    //////////////////////////////
    always_comb
    begin
        lzc = 6'(`FMA_SUM_W);
        for (int i = 0; i < `FMA_SUM_W; i++)
        begin
            if (sum.sm[i])
                lzc = 6'(`FMA_SUM_W - 1 - i);  // highest set bit wins
        end
        // a carry into bit 29 just means a smaller count, no right shift needed
        lmax  = sum.re + 7'sd6;           // shift that lands on exponent 1
        sh    = ({1'b0, lzc} > lmax) ? lmax[5:0] : lzc;
        nrm   = sum.sm << sh;
        e_nrm = sum.re + 7'sd7 - 7'(sh);

        norm.sign = sum.ms;
        norm.exp  = nrm[`FMA_SUM_W-1] ? e_nrm[4:0] : 5'd0;  // no leading one -> subnormal
        norm.man  = nrm[`FMA_SUM_W-1 -: 11];
        norm.g    = nrm[`FMA_SUM_W-12];
        norm.r    = nrm[`FMA_SUM_W-13];
        norm.s    = |nrm[`FMA_SUM_W-14:0] | sum.sticky;
        norm.rm   = sum.rm;
    end

    fma16_round u_round (
        .norm   (norm),
        .result (rnd),
        .nx     (nx)
    );

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            rsp_valid <= 1'b0;
        else
            rsp_valid <= sum_valid;
    end

    always_ff @(posedge clk)
    begin
        if (sum_valid)
        begin
            if (sum.zero)
            begin
                rsp.result <= '{sign: sum.ms, exp: 5'd0, frac: 10'd0};  // sign set in stage 1
                rsp.nx     <= 1'b0;
            end
            else
            begin
                rsp.result <= rnd;
                rsp.nx     <= nx;
            end
        end
    end

endmodule

//--- hdl/fma16_axil_regs.sv
// fma16 AXI4-Lite register block
// holds x, y, z and the rounding mode, pulses start on a CTRL write
// and captures the pipeline result into STATUS
`timescale 1ns/1ns
`include "fma16_macros.svh"

module fma16_axil_regs (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fma16_pkg::axil_req_t axil_req,
    output fma16_pkg::axil_rsp_t axil_rsp,
    output logic                 start,
    output fma16_pkg::fma_req_t  req,
    input  logic                 rsp_valid,
    input  fma16_pkg::fma_rsp_t  rsp
);
    import fma16_pkg::*;

    logic                      aw_held, aw_held_d, aw_hs;
    logic                      w_held, w_held_d, w_hs;
    logic [`AXIL_ADDR_W-1:0]   aw_addr_q, wr_addr;
    logic [`AXIL_DATA_W-1:0]   w_data_q, wr_data;
    logic [`AXIL_DATA_W/8-1:0] w_strb_q, wr_strb;
    logic                      wr_fire, wr_ok;
    logic                      awready_q, wready_q, bvalid_q, bvalid_d;
    resp_e                     bresp_q;
    logic                      arready_q, rvalid_q, rvalid_d, ar_hs;
    logic [`AXIL_DATA_W-1:0]   rdata_q, rd_word;
    resp_e                     rresp_q, rd_resp;
    fp16_t                     x_q, y_q, z_q, result_q;
    round_mode_e               rm_q;
    logic                      done_q, nx_q;
    logic [`AXIL_DATA_W-1:0]   xy_merged, z_old, z_merged;

    // byte-lane write merge
    function automatic logic [`AXIL_DATA_W-1:0] merge_bytes(
        input logic [`AXIL_DATA_W-1:0]   old,
        input logic [`AXIL_DATA_W-1:0]   data,
        input logic [`AXIL_DATA_W/8-1:0] strb
    );
        logic [`AXIL_DATA_W-1:0] res;
        res = old;
        for (int i = 0; i < `AXIL_DATA_W/8; i++)
        begin
            if (strb[i])
                res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    //////////////////////////////
    // write channel
    //////////////////////////////
    assign aw_hs   = axil_req.awvalid & awready_q;
    assign w_hs    = axil_req.wvalid & wready_q;
    assign wr_fire = (aw_held | aw_hs) & (w_held | w_hs);  // second of the two acceptances
    assign wr_addr = aw_held ? aw_addr_q : axil_req.awaddr;
    assign wr_data = w_held ? w_data_q : axil_req.wdata;
    assign wr_strb = w_held ? w_strb_q : axil_req.wstrb;

    assign aw_held_d = ~wr_fire & (aw_held | aw_hs);
    assign w_held_d  = ~wr_fire & (w_held | w_hs);
    assign bvalid_d  = wr_fire | (bvalid_q & ~axil_req.bready);

    assign wr_ok = (wr_addr == `REG_XY) | (wr_addr == `REG_Z) | (wr_addr == `REG_CTRL);
    assign start = wr_fire & (wr_addr == `REG_CTRL) & wr_data[`CTRL_START_BIT];

    assign z_old     = {{(`AXIL_DATA_W-`Z_RM_LSB-2){1'b0}}, rm_q, z_q};
    assign xy_merged = merge_bytes({y_q, x_q}, wr_data, wr_strb);
    assign z_merged  = merge_bytes(z_old, wr_data, wr_strb);

    //////////////////////////////
    // read channel
    //////////////////////////////
    assign ar_hs    = axil_req.arvalid & arready_q;
    assign rvalid_d = ar_hs | (rvalid_q & ~axil_req.rready);

    always_comb
    begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        case (axil_req.araddr)
            `REG_XY:     rd_word = {y_q, x_q};
            `REG_Z:      rd_word = z_old;
            `REG_CTRL:   rd_word = '0;                  // start is self-clearing
            `REG_STATUS:
            begin
                rd_word[15:0]            = result_q;
                rd_word[`STAT_DONE_BIT]  = done_q;
                rd_word[`STAT_NX_BIT]    = nx_q;
            end
            default:     rd_resp = RESP_SLVERR;         // hole in the map
        endcase
    end

    // control state, handshakes and the program-visible registers
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            aw_held   <= 1'b0;
            w_held    <= 1'b0;
            awready_q <= 1'b0;
            wready_q  <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
            rresp_q   <= RESP_OKAY;
            rdata_q   <= '0;
            x_q       <= '0;
            y_q       <= '0;
            z_q       <= '0;
            rm_q      <= RND_NEAR_EVEN;
            done_q    <= 1'b0;
            nx_q      <= 1'b0;
            result_q  <= '0;
        end
        else
        begin
            aw_held   <= aw_held_d;
            w_held    <= w_held_d;
            awready_q <= ~aw_held_d & ~bvalid_d;   // stalls while a response waits
            wready_q  <= ~w_held_d & ~bvalid_d;
            bvalid_q  <= bvalid_d;
            arready_q <= ~rvalid_d;
            rvalid_q  <= rvalid_d;
            if (wr_fire)
                bresp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            if (ar_hs)
            begin
                rdata_q <= rd_word;
                rresp_q <= rd_resp;
            end
            if (wr_fire && wr_addr == `REG_XY)
                {y_q, x_q} <= xy_merged;
            if (wr_fire && wr_addr == `REG_Z)
            begin
                z_q  <= z_merged[15:0];
                rm_q <= round_mode_e'(z_merged[`Z_RM_LSB +: 2]);
            end
            if (start)
                done_q <= 1'b0;                    // new op hides the old result
            else if (rsp_valid)
            begin
                done_q   <= 1'b1;
                result_q <= rsp.result;
                nx_q     <= rsp.nx;
            end
        end
    end

    // address/data held until the other half of the write shows up
    always_ff @(posedge clk)
    begin
        if (aw_hs)
            aw_addr_q <= axil_req.awaddr;
        if (w_hs)
        begin
            w_data_q <= axil_req.wdata;
            w_strb_q <= axil_req.wstrb;
        end
    end

    assign req = '{x: x_q, y: y_q, z: z_q, rm: rm_q};

    assign axil_rsp = '{awready: awready_q, wready: wready_q, bresp: bresp_q,
                        bvalid: bvalid_q, arready: arready_q, rdata: rdata_q,
                        rresp: rresp_q, rvalid: rvalid_q};

endmodule

//--- hdl/fma16_top.sv
// fma16 top level
// AXI4-Lite register block feeding the two-stage fused multiply-add pipeline
`timescale 1ns/1ns

module fma16_top (
    input  logic                 clk,
    input  logic                 arst_n,
    input  fma16_pkg::axil_req_t axil_req,
    output fma16_pkg::axil_rsp_t axil_rsp
);
    import fma16_pkg::*;

    logic       start;
    fma_req_t   req;
    logic       sum_valid;
    sum_stage_t sum;       // stage 1 register
    logic       rsp_valid;
    fma_rsp_t   rsp;       // stage 2 register

    fma16_axil_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .axil_req  (axil_req),
        .axil_rsp  (axil_rsp),
        .start     (start),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

    fma16_mult_align u_mult_align (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start),
        .req       (req),
        .sum_valid (sum_valid),
        .sum       (sum)
    );

    fma16_result u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .sum_valid (sum_valid),
        .sum       (sum),
        .rsp_valid (rsp_valid),
        .rsp       (rsp)
    );

endmodule

//--- tests/fma16_tb.sv
// fma16 testbench
// drives the AXI4-Lite port of fma16_top through directed tests of
// exact integer sums, identities, ties, subnormals and bus behavior
`timescale 1ns/1ns
`include "fma16_macros.svh"

module fma16_tb;
    import fma16_pkg::*;

    localparam int N_RAND      = 6;                              // random operands in identity test
    localparam int NUM_OPS     = 12 + 6 * N_RAND + 8 + 5 + 12;   // bus accesses and operations
    localparam int CYCLE_LIMIT = 40 * NUM_OPS + 200;

    logic      clk;
    logic      arst_n;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    int        errors = 0;
    int        checks = 0;
    int        cycles = 0;
    integer    seed = 32'hc30a_4c2d;

    fma16_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;   // 100 ns period

    // run limit
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("ERROR: timeout after %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic compare_fp16(input string name, input fp16_t expected, input fp16_t actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_nx(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_resp(input string name, input resp_e expected, input resp_e actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: expected 0x%h, got 0x%h", name, expected, actual);
            errors++;
        end
    endtask

    // exactly representable real to half word
    function automatic fp16_t to_fp16(input real v);
        fp16_t f;
        real   a;
        int    e;
        f = '0;
        f.sign = (v < 0.0);
        a = f.sign ? -v : v;
        e = 15;                                 // biased exponent of 1.0
        if (a != 0.0)
        begin
            while (a >= 2.0)
            begin
                a = a / 2.0;
                e++;
            end
            while (a < 1.0 && e > 1)
            begin
                a = a * 2.0;
                e--;
            end
            if (a >= 1.0)
            begin
                f.exp  = 5'(e);
                f.frac = 10'($rtoi((a - 1.0) * 1024.0));
            end
            else
                f.frac = 10'($rtoi(a * 1024.0));  // subnormal, units of 2^-24
        end
        return f;
    endfunction

    //////////////////////////////
    // bus tasks
    //////////////////////////////
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                              input resp_e exp_resp, input int hold_b);
        logic aw_pend, w_pend, aw_acc, w_acc;
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.awvalid <= 1'b1;
        axil_req.wdata   <= data;
        axil_req.wstrb   <= '1;
        axil_req.wvalid  <= 1'b1;
        axil_req.bready  <= (hold_b == 0);
        aw_pend = 1'b1;
        w_pend  = 1'b1;
        while (aw_pend || w_pend)
        begin
            @(negedge clk);
            aw_acc = aw_pend && axil_rsp.awready;   // taken on the coming edge
            w_acc  = w_pend && axil_rsp.wready;
            @(posedge clk);
            if (aw_acc)
            begin
                axil_req.awvalid <= 1'b0;
                aw_pend = 1'b0;
            end
            if (w_acc)
            begin
                axil_req.wvalid <= 1'b0;
                w_pend = 1'b0;
            end
        end
        if (hold_b > 0)
        begin
            repeat (hold_b)
            begin
                @(negedge clk);
                checks++;
                if (!axil_rsp.bvalid)
                begin
                    $display("ERROR: bvalid dropped while bready was held low");
                    errors++;
                end
            end
            @(posedge clk);
            axil_req.bready <= 1'b1;
        end
        @(negedge clk);
        while (!axil_rsp.bvalid)
            @(negedge clk);
        compare_resp($sformatf("bresp @0x%h", addr), exp_resp, axil_rsp.bresp);
        @(posedge clk);
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, input resp_e exp_resp,
                             output logic [31:0] data);
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        axil_req.rready  <= 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready)
            @(negedge clk);
        @(posedge clk);                          // address taken here
        axil_req.arvalid <= 1'b0;
        @(negedge clk);
        while (!axil_rsp.rvalid)
            @(negedge clk);
        data = axil_rsp.rdata;
        compare_resp($sformatf("rresp @0x%h", addr), exp_resp, axil_rsp.rresp);
        @(posedge clk);
        axil_req.rready <= 1'b0;
    endtask

    // polls STATUS a bounded number of times
    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[`STAT_DONE_BIT] && polls < 8)
        begin
            axil_read(`REG_STATUS, RESP_OKAY, status);
            polls++;
        end
        checks++;
        if (!status[`STAT_DONE_BIT])
        begin
            $display("ERROR: done never set after %0d status reads", polls);
            errors++;
        end
    endtask

    task automatic check_fma(input string tag, input fp16_t x, y, z, input round_mode_e rm,
                             input fp16_t exp_res, input logic exp_nx);
        logic [31:0] status;
        axil_write(`REG_XY, {y, x}, RESP_OKAY, 0);
        axil_write(`REG_Z, {14'd0, rm, z}, RESP_OKAY, 0);
        axil_write(`REG_CTRL, 32'h1 << `CTRL_START_BIT, RESP_OKAY, 0);
        wait_done(status);
        compare_fp16($sformatf("%s result", tag), exp_res, fp16_t'(status[15:0]));
        compare_nx($sformatf("%s nx", tag), exp_nx, status[`STAT_NX_BIT]);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    // operands in units of 0.5 and the sum in units of 0.25
    task automatic exact_case(input int x2, y2, z2);
        fp16_t x, y, z, expected;
        x = to_fp16(x2 / 2.0);
        y = to_fp16(y2 / 2.0);
        z = to_fp16(z2 / 2.0);
        expected = to_fp16((x2 * y2 + 2 * z2) / 4.0);
        for (int m = 0; m < 4; m++)
            check_fma($sformatf("exact %0d*%0d+%0d rm%0d", x2, y2, z2, m),
                      x, y, z, round_mode_e'(2'(m)), expected, 1'b0);
    endtask

    task automatic exact_int_cases();
        exact_case(6, 10, 2);      // 3*5+1 = 16
        exact_case(5, -8, 1);      // 2.5*-4+0.5 = -9.5
        exact_case(14, -12, 100);  // 7*-6+50 = 8
    endtask

    task automatic identity_cases();
        logic [31:0] r;
        fp16_t       x, z, one, pzero, zero_res;
        round_mode_e rm, mrm;
        one   = to_fp16(1.0);
        pzero = '0;
        for (int i = 0; i < N_RAND; i++)
        begin
            r  = $random(seed);
            x  = '{sign: r[14], exp: 5'd7 + 5'(r[3:0]), frac: r[13:4]};  // 2^-8 .. <2^8
            rm = round_mode_e'(r[16:15]);
            check_fma("x*1+0", x, one, pzero, rm, x, 1'b0);
            z = '{sign: ~x.sign, exp: x.exp, frac: x.frac};
            for (int m = 0; m < 4; m++)
            begin
                mrm      = round_mode_e'(2'(m));
                zero_res = '{sign: (mrm == RND_DOWN), exp: 5'd0, frac: 10'd0};  // -0 only down
                check_fma("x*1-x", x, one, z, mrm, zero_res, 1'b0);
            end
            r = $random(seed);
            z = '{sign: r[5], exp: 5'd1 + 5'(r[4:0] % 5'd30), frac: r[15:6]};
            check_fma("x*0+z", x, pzero, z, rm, z, 1'b0);
        end
    endtask

    // 1 + 2^-11 sits halfway between 1.0 and 1 + 2^-10
    task automatic tie_cases();
        real         sgn;
        fp16_t       one, lo, hi;
        round_mode_e rm;
        logic        away;
        one = to_fp16(1.0);
        for (int neg = 0; neg < 2; neg++)
        begin
            sgn = (neg != 0) ? -1.0 : 1.0;
            lo  = to_fp16(sgn);
            hi  = to_fp16(sgn * (1.0 + 1.0 / 1024.0));
            for (int m = 0; m < 4; m++)
            begin
                rm = round_mode_e'(2'(m));
                // even neighbour is lo, so only rounding toward the sign's infinity moves
                away = (rm == RND_UP && neg == 0) || (rm == RND_DOWN && neg != 0);
                check_fma($sformatf("tie neg%0d rm%0d", neg, m), lo, one,
                          to_fp16(sgn / 2048.0), rm, away ? hi : lo, 1'b1);
            end
        end
    endtask

    task automatic subnormal_cases();
        fp16_t sx, sz, expected;
        check_fma("2^-14*0.5", to_fp16(1.0 / 16384.0), to_fp16(0.5), '0, RND_NEAR_EVEN,
                  to_fp16(1.0 / 32768.0), 1'b0);
        sx = 16'h0003;                                  // 3 units of 2^-24
        sz = 16'h0105;
        expected = '{sign: 1'b0, exp: 5'd0, frac: 10'(3 * 2 + 'h105)};  // integer sum of units
        for (int m = 0; m < 4; m++)
            check_fma($sformatf("sub+sub rm%0d", m), sx, to_fp16(2.0), sz,
                      round_mode_e'(2'(m)), expected, 1'b0);
    endtask

    task automatic bus_behavior();
        logic [31:0] w;
        axil_read(`REG_STATUS, RESP_OKAY, w);
        compare_word("STATUS after reset", 32'h0, w);
        axil_write(`REG_XY, 32'h4400_3C00, RESP_OKAY, 0);
        axil_write(4'h2, 32'hdead_beef, RESP_SLVERR, 0);     // hole in the map
        axil_read(`REG_XY, RESP_OKAY, w);
        compare_word("XY after bad write", 32'h4400_3C00, w);
        axil_read(4'h2, RESP_SLVERR, w);
        axil_write(`REG_STATUS, 32'h0003_ffff, RESP_SLVERR, 0);
        axil_read(`REG_STATUS, RESP_OKAY, w);
        compare_word("STATUS after write", 32'h0, w);
        // response held back for 5 cycles
        axil_write(`REG_Z, {14'd0, RND_UP, 16'h5140}, RESP_OKAY, 5);
        axil_read(`REG_Z, RESP_OKAY, w);
        compare_word("Z after held bready", {14'd0, RND_UP, 16'h5140}, w);
        // done must drop while the restarted op is in flight
        check_fma("restart base", to_fp16(3.0), to_fp16(5.0), to_fp16(1.0), RND_NEAR_EVEN,
                  to_fp16(16.0), 1'b0);
        fork
            axil_write(`REG_CTRL, 32'h1 << `CTRL_START_BIT, RESP_OKAY, 0);
            begin
                @(posedge clk);                           // read lands one cycle after start
                axil_read(`REG_STATUS, RESP_OKAY, w);
            end
        join
        compare_word("STATUS done after restart", 32'h0, w & (32'h1 << `STAT_DONE_BIT));
        wait_done(w);
        compare_fp16("restart result", to_fp16(16.0), fp16_t'(w[15:0]));
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////
    initial
    begin
        axil_req = '0;
        arst_n   = 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        bus_behavior();
        exact_int_cases();
        identity_cases();
        tie_cases();
        subnormal_cases();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Testbench passed");
        end
        else
        begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+hdl
hdl/fma16_pkg.sv
hdl/fma16_round.sv
hdl/fma16_mult_align.sv
hdl/fma16_result.sv
hdl/fma16_axil_regs.sv
hdl/fma16_top.sv
tests/fma16_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the fma16 testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module fma16_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vfma16_tb > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
